// File: dcache.f
src/dcache_pkg.sv
src/cache_ways.sv
src/miss_controller.sv
src/dcache.sv
tests/mem_model.sv
tests/dcache_assertions.sv
tests/dcache_tb.sv

// File: tests/dcache_tb.sv
/*
 testbench for the two-way data cache
   clock, reset and a stimulus table applied in a loop
   reference array with the latest value per word address
   memory-side monitor for write-back data, addresses and read counts
 */

`timescale 1ns/1ps

module dcache_tb;

   localparam int          MEM_WORDS = 1024;
   localparam int          N_RAND    = 300;
   localparam int          TIMEOUT   = 200;
   localparam logic [31:0] SEED      = 32'h043793ef;

   logic              CLK;
   logic              nRST;
   logic              dmemREN;
   logic              dmemWEN;
   logic              dhit;
   logic              dREN;
   logic              dWEN;
   logic              dwait;
   dcache_pkg::word_t dmemaddr;
   dcache_pkg::word_t dmemstore;
   dcache_pkg::word_t dmemload;
   dcache_pkg::word_t dload;
   dcache_pkg::word_t daddr;
   dcache_pkg::word_t dstore;

   // stimulus table, 1 = write
   logic              op_q [$];
   dcache_pkg::word_t addr_q [$];
   dcache_pkg::word_t store_q [$];
   // expected completed reads and writes on the memory port, -1 unchecked
   int                nrd_q [$];
   int                nwr_q [$];
   // victim block address of an expected write-back
   dcache_pkg::word_t wb_q [$];

   // latest value of every word
   dcache_pkg::word_t ref_mem [MEM_WORDS];

   // memory traffic of the current request
   int                n_rd;
   dcache_pkg::word_t wb_seen [$];

   dcache dut_i (
      .CLK       (CLK),
      .nRST      (nRST),
      .dmemREN   (dmemREN),
      .dmemWEN   (dmemWEN),
      .dmemaddr  (dmemaddr),
      .dmemstore (dmemstore),
      .dload     (dload),
      .dwait     (dwait),
      .dmemload  (dmemload),
      .dhit      (dhit),
      .dREN      (dREN),
      .dWEN      (dWEN),
      .daddr     (daddr),
      .dstore    (dstore)
   );

   mem_model mem_i (
      .CLK    (CLK),
      .nRST   (nRST),
      .dREN   (dREN),
      .dWEN   (dWEN),
      .daddr  (daddr),
      .dstore (dstore),
      .dload  (dload),
      .dwait  (dwait)
   );

   always #50 CLK = ~CLK;

   function automatic int word_index(input dcache_pkg::word_t a);
      return int'(a[11:2]);
   endfunction

   // address from its cache fields
   function automatic dcache_pkg::word_t make_addr(input int tag, input int idx, input int blk);
      dcache_pkg::dcache_addr_u a;
      a.word  = '0;
      a.f.tag = tag;
      a.f.idx = idx;
      a.f.blk = blk;
      return a.word;
   endfunction

   task automatic stop_on_error();
      $display("tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input dcache_pkg::word_t got,
                             input dcache_pkg::word_t exp);
      assert (got === exp) else begin
         $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic add_entry(input logic wr, input dcache_pkg::word_t a,
                            input dcache_pkg::word_t d, input int nrd, input int nwr,
                            input dcache_pkg::word_t wb);
      op_q.push_back(wr);
      addr_q.push_back(a);
      store_q.push_back(d);
      nrd_q.push_back(nrd);
      nwr_q.push_back(nwr);
      wb_q.push_back(wb);
   endtask

   task automatic build_table();
      dcache_pkg::word_t a0;
      dcache_pkg::word_t a1;
      dcache_pkg::word_t b0;
      dcache_pkg::word_t b1;
      dcache_pkg::word_t c0;
      // three tags on set 1
      a0 = make_addr(1, 1, 0);
      a1 = make_addr(1, 1, 1);
      b0 = make_addr(2, 1, 0);
      b1 = make_addr(2, 1, 1);
      c0 = make_addr(3, 1, 0);
      // read miss, then other word of the block
      add_entry(1'b0, a0, '0, 2, 0, '0);
      add_entry(1'b0, a1, '0, 0, 0, '0);
      // write hit, write miss, read back
      add_entry(1'b1, a0, 32'h1111_0001, 0, 0, '0);
      add_entry(1'b0, a0, '0, 0, 0, '0);
      add_entry(1'b1, b1, 32'h2222_0002, 2, 0, '0);
      add_entry(1'b0, b1, '0, 0, 0, '0);
      // touch way 0, so dirty way 1 gets evicted
      add_entry(1'b0, a1, '0, 0, 0, '0);
      add_entry(1'b0, c0, '0, 2, 2, b0);
      add_entry(1'b0, a0, '0, 0, 0, '0);
      // evicted block comes back, clean victim
      add_entry(1'b0, b1, '0, 2, 0, '0);
      add_entry(1'b0, b0, '0, 0, 0, '0);
      // dirty way 0 goes out next
      add_entry(1'b0, c0, '0, 2, 2, a0);
      add_entry(1'b0, a0, '0, 2, 0, '0);
      // random mix over sets 0 and 2
      for (int i = 0; i < N_RAND; i++) begin
         add_entry(1'($urandom_range(1, 0)),
                   make_addr($urandom_range(4, 1), 2 * $urandom_range(1, 0),
                             $urandom_range(1, 0)),
                   $urandom, -1, -1, '0);
      end
   endtask

   // one request held until dhit, then committed at the next rising edge
   task automatic run_request(input int k);
      int cyc;
      @(negedge CLK);
      dmemREN   = !op_q[k];
      dmemWEN   = op_q[k];
      dmemaddr  = addr_q[k];
      dmemstore = store_q[k];
      n_rd      = 0;
      wb_seen.delete();
      cyc       = 0;
      #10;
      while (!dhit) begin
         cyc++;
         if (cyc > TIMEOUT) begin
            $display("no dhit within %0d cycles for table entry %0d", TIMEOUT, k);
            stop_on_error();
         end
         @(negedge CLK);
         #10;
      end
      if (!op_q[k]) begin
         check_word("dmemload", dmemload, ref_mem[word_index(addr_q[k])]);
      end
      if (nrd_q[k] >= 0) begin
         check_word("dREN count", n_rd, nrd_q[k]);
      end
      if (nwr_q[k] >= 0) begin
         check_word("dWEN count", wb_seen.size(), nwr_q[k]);
      end
      if (nwr_q[k] == 2) begin
         check_word("daddr", wb_seen[0], wb_q[k]);
         check_word("daddr", wb_seen[1], wb_q[k] | 32'h4);
      end
      // store lands at this edge
      @(posedge CLK);
      if (op_q[k]) begin
         ref_mem[word_index(addr_q[k])] = store_q[k];
      end
   endtask

   // completed memory accesses
   always @(posedge CLK) begin
      if (nRST && !dwait && dREN) begin
         n_rd++;
      end
      if (nRST && !dwait && dWEN) begin
         check_word("dstore", dstore, ref_mem[word_index(daddr)]);
         wb_seen.push_back(daddr);
      end
   end

   initial begin
      void'($urandom(SEED));
      CLK       = 1'b0;
      nRST      = 1'b0;
      // read request held through reset, no line may hit
      dmemREN   = 1'b1;
      dmemWEN   = 1'b0;
      dmemaddr  = make_addr(1, 1, 0);
      dmemstore = '0;
      n_rd      = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i] = (i << 2) ^ 32'h5a5a0000;
      end
      build_table();
      // 4 cycles in reset, port quiet
      for (int i = 0; i < 4; i++) begin
         @(posedge CLK);
         #10;
         check_word("dhit", dhit, 0);
         check_word("dREN", dREN, 0);
         check_word("dWEN", dWEN, 0);
      end
      @(negedge CLK);
      nRST    = 1'b1;
      dmemREN = 1'b0;
      #10;
      check_word("dhit", dhit, 0);
      check_word("dREN", dREN, 0);
      check_word("dWEN", dWEN, 0);
      for (int k = 0; k < op_q.size(); k++) begin
         run_request(k);
      end
      @(negedge CLK);
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
      $display("all tests passed");
      $finish;
   end

endmodule

// File: tests/dcache_assertions.sv
/*
 concurrent checks on the cache memory port
   read and write enables exclusive
   word aligned memory address during an access
   no fill while a memory access is open
 */

`timescale 1ns/1ps

module dcache_assertions (
   input logic              CLK,
   input logic              nRST,
   input logic              dREN,
   input logic              dWEN,
   input dcache_pkg::word_t daddr,
   input logic              fill_en
);

   // one access at a time
   enables_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
      !(dREN && dWEN))
      else $error("dREN and dWEN are high in the same cycle");

   // byte offset always zero on the memory side
   addr_aligned: assert property (@(posedge CLK) disable iff (!nRST)
      (dREN || dWEN) |-> (daddr[1:0] == 2'b00))
      else $error("daddr is not word aligned during a memory access");

   // fill comes after both fetches have ended
   fill_quiet: assert property (@(posedge CLK) disable iff (!nRST)
      fill_en |-> !(dREN || dWEN))
      else $error("fill_en is high while a memory enable is high");

endmodule

bind dcache dcache_assertions asrt_i (
   .CLK     (CLK),
   .nRST    (nRST),
   .dREN    (dREN),
   .dWEN    (dWEN),
   .daddr   (daddr),
   .fill_en (fill_en)
);

// File: tests/mem_model.sv
/*
 behavioral word memory for the cache testbench
   1024 words, each word starts as its byte address ^ 32'h5a5a0000
   0 to 3 random wait cycles per access
 */

`timescale 1ns/1ps

module mem_model (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dREN,
   input  logic              dWEN,
   input  dcache_pkg::word_t daddr,
   input  dcache_pkg::word_t dstore,
   output dcache_pkg::word_t dload,
   output logic              dwait
);

   localparam int MEM_WORDS = 1024;

   dcache_pkg::word_t mem [MEM_WORDS];
   // wait cycles left before the current access ends
   logic [1:0] wait_q;
   logic [9:0] widx;

   assign widx  = daddr[11:2];
   assign dload = mem[widx];
   assign dwait = (dREN || dWEN) && (wait_q != 2'd0);

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = (i << 2) ^ 32'h5a5a0000;
      end
   end

   always @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         wait_q <= 2'd0;
      end
      else if (dREN || dWEN) begin
         if (wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
         end
         else begin
            // access ends here, draw the stall of the next one
            if (dWEN) begin
               mem[widx] <= dstore;
            end
            wait_q <= 2'($urandom_range(3, 0));
         end
      end
   end

endmodule

// File: src/dcache.sv
/*
 two-way set-associative write-back data cache
   processor side: load/store strobes, address, store data, load data, dhit
   memory side: word port with wait states
   storage (cache_ways) and miss FSM (miss_controller)
 */

`timescale 1ns/1ps

module dcache (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dmemREN,
   input  logic              dmemWEN,
   input  dcache_pkg::word_t dmemaddr,
   input  dcache_pkg::word_t dmemstore,
   input  dcache_pkg::word_t dload,
   input  logic              dwait,
   output dcache_pkg::word_t dmemload,
   output logic              dhit,
   output logic              dREN,
   output logic              dWEN,
   output dcache_pkg::word_t daddr,
   output dcache_pkg::word_t dstore
);

   // victim readout toward the controller
   logic                          victim_dirty;
   logic [dcache_pkg::DTAG_W-1:0] victim_tag;
   dcache_pkg::word_t             victim_word;

   // write-back word select and block fill
   logic [dcache_pkg::DBLK_W-1:0] wb_word;
   logic                          fill_en;
   dcache_pkg::word_t             fill_data0;
   dcache_pkg::word_t             fill_data1;

   // tags, data, hit detection
   // hit doubles as dhit
   cache_ways ways_i (
      .CLK          (CLK),
      .nRST         (nRST),
      .dmemREN      (dmemREN),
      .dmemWEN      (dmemWEN),
      .dmemaddr     (dmemaddr),
      .dmemstore    (dmemstore),
      .wb_word      (wb_word),
      .fill_en      (fill_en),
      .fill_data0   (fill_data0),
      .fill_data1   (fill_data1),
      .hit          (dhit),
      .dmemload     (dmemload),
      .victim_dirty (victim_dirty),
      .victim_tag   (victim_tag),
      .victim_word  (victim_word)
   );

   // write-back and refill over the memory port
   miss_controller ctrl_i (
      .CLK          (CLK),
      .nRST         (nRST),
      .dmemREN      (dmemREN),
      .dmemWEN      (dmemWEN),
      .dmemaddr     (dmemaddr),
      .hit          (dhit),
      .victim_dirty (victim_dirty),
      .victim_tag   (victim_tag),
      .victim_word  (victim_word),
      .dload        (dload),
      .dwait        (dwait),
      .dREN         (dREN),
      .dWEN         (dWEN),
      .daddr        (daddr),
      .dstore       (dstore),
      .wb_word      (wb_word),
      .fill_en      (fill_en),
      .fill_data0   (fill_data0),
      .fill_data1   (fill_data1)
   );

endmodule

// File: src/miss_controller.sv
/*
 miss handling for the data cache
   FSM: idle, write-back of both victim words, fetch of both block words, fill
   memory port drive (enables, word address, store data)
   registers for the two fetched words, presented as the fill block
 */

`timescale 1ns/1ps

module miss_controller (
   input  logic                              CLK,
   input  logic                              nRST,
   input  logic                              dmemREN,
   input  logic                              dmemWEN,
   input  dcache_pkg::word_t                 dmemaddr,
   input  logic                              hit,
   input  logic                              victim_dirty,
   input  logic [dcache_pkg::DTAG_W-1:0]     victim_tag,
   input  dcache_pkg::word_t                 victim_word,
   input  dcache_pkg::word_t                 dload,
   input  logic                              dwait,
   output logic                              dREN,
   output logic                              dWEN,
   output dcache_pkg::word_t                 daddr,
   output dcache_pkg::word_t                 dstore,
   output logic [dcache_pkg::DBLK_W-1:0]     wb_word,
   output logic                              fill_en,
   output dcache_pkg::word_t                 fill_data0,
   output dcache_pkg::word_t                 fill_data1
);

   // state codes
   localparam logic [2:0] ST_IDLE   = 3'd0;
   localparam logic [2:0] ST_WB0    = 3'd1;
   localparam logic [2:0] ST_WB1    = 3'd2;
   localparam logic [2:0] ST_FETCH0 = 3'd3;
   localparam logic [2:0] ST_FETCH1 = 3'd4;
   localparam logic [2:0] ST_FILL   = 3'd5;

   logic [2:0] state_q;
   logic [2:0] state_d;

   // request and memory addresses
   dcache_pkg::dcache_addr_u req;
   dcache_pkg::dcache_addr_u mem_a;

   // fetched block words
   dcache_pkg::word_t word0_q;
   dcache_pkg::word_t word1_q;

   logic req_miss;

   assign req.word = dmemaddr;
   assign req_miss = (dmemREN || dmemWEN) && !hit;

   // next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            // clean or empty victim skips the write-back
            if (req_miss) begin
               state_d = victim_dirty ? ST_WB0 : ST_FETCH0;
            end
         end
         ST_WB0: begin
            if (!dwait) begin
               state_d = ST_WB1;
            end
         end
         ST_WB1: begin
            if (!dwait) begin
               state_d = ST_FETCH0;
            end
         end
         ST_FETCH0: begin
            if (!dwait) begin
               state_d = ST_FETCH1;
            end
         end
         ST_FETCH1: begin
            if (!dwait) begin
               state_d = ST_FILL;
            end
         end
         ST_FILL: begin
            // request hits in the following cycle
            state_d = ST_IDLE;
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   // outputs decoded from the state
   assign dWEN    = (state_q == ST_WB0) || (state_q == ST_WB1);
   assign dREN    = (state_q == ST_FETCH0) || (state_q == ST_FETCH1);
   assign fill_en = (state_q == ST_FILL);
   assign wb_word = (state_q == ST_WB1);

   // memory word address
   // write-back goes to the victim's own block
   always_comb begin
      mem_a       = req;
      mem_a.f.byt = '0;
      if (dWEN) begin
         mem_a.f.tag = victim_tag;
         mem_a.f.blk = wb_word;
      end
      else begin
         mem_a.f.blk = (state_q == ST_FETCH1);
      end
   end

   assign daddr  = mem_a.word;
   // victim word already selected by wb_word
   assign dstore = victim_word;

   // fill block
   assign fill_data0 = word0_q;
   assign fill_data1 = word1_q;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state_q <= ST_IDLE;
      end
      else begin
         state_q <= state_d;
      end
   end

   // capture each word as its read completes
   always_ff @(posedge CLK) begin
      if (state_q == ST_FETCH0 && !dwait) begin
         word0_q <= dload;
      end
      if (state_q == ST_FETCH1 && !dwait) begin
         word1_q <= dload;
      end
   end

endmodule

// File: src/cache_ways.sv
/*
 storage for both ways of the data cache
   valid, dirty, tag and two data words per way and set
   one replacement bit per set (most recently used way)
   tag compare, hit and load data
   store merge on write hits, block fill from the miss controller
   victim selection and victim readout for write-back
 */

`timescale 1ns/1ps

module cache_ways (
   input  logic                              CLK,
   input  logic                              nRST,
   input  logic                              dmemREN,
   input  logic                              dmemWEN,
   input  dcache_pkg::word_t                 dmemaddr,
   input  dcache_pkg::word_t                 dmemstore,
   input  logic [dcache_pkg::DBLK_W-1:0]     wb_word,
   input  logic                              fill_en,
   input  dcache_pkg::word_t                 fill_data0,
   input  dcache_pkg::word_t                 fill_data1,
   output logic                              hit,
   output dcache_pkg::word_t                 dmemload,
   output logic                              victim_dirty,
   output logic [dcache_pkg::DTAG_W-1:0]     victim_tag,
   output dcache_pkg::word_t                 victim_word
);

   // decoded request address
   dcache_pkg::dcache_addr_u req;
   logic [dcache_pkg::DIDX_W-1:0] idx;
   logic [dcache_pkg::DBLK_W-1:0] blk;

   // line state, cleared on reset
   logic [dcache_pkg::N_WAYS-1:0][dcache_pkg::N_SETS-1:0] valid_q;
   logic [dcache_pkg::N_WAYS-1:0][dcache_pkg::N_SETS-1:0] dirty_q;
   // way touched last in each set
   logic [dcache_pkg::N_SETS-1:0] lru_q;

   // tags and data words
   logic [dcache_pkg::DTAG_W-1:0] tag_q [dcache_pkg::N_WAYS][dcache_pkg::N_SETS];
   dcache_pkg::word_t data_q [dcache_pkg::N_WAYS][dcache_pkg::N_SETS][1 << dcache_pkg::DBLK_W];

   // compare results
   logic [dcache_pkg::N_WAYS-1:0] way_hit;
   logic hit_way;
   logic wr_hit;

   // way picked for replacement in the addressed set
   logic victim;

   assign req.word = dmemaddr;
   assign idx      = req.f.idx;
   assign blk      = req.f.blk;

   // tag compare against every way of the set
   always_comb begin
      for (int w = 0; w < dcache_pkg::N_WAYS; w++) begin
         way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == req.f.tag);
      end
   end

   // only a live request can hit
   assign hit     = (dmemREN || dmemWEN) && (|way_hit);
   // way 1 or way 0
   assign hit_way = way_hit[1];
   assign wr_hit  = hit && dmemWEN;

   // load data from the matching way
   assign dmemload = data_q[hit_way][idx][blk];

   // empty way first, way 0 before way 1
   // otherwise the one not used last
   always_comb begin
      if (!valid_q[0][idx]) begin
         victim = 1'b0;
      end
      else if (!valid_q[1][idx]) begin
         victim = 1'b1;
      end
      else begin
         victim = ~lru_q[idx];
      end
   end

   // victim info for the write-back path
   // an invalid way is never dirty
   assign victim_dirty = valid_q[victim][idx] && dirty_q[victim][idx];
   assign victim_tag   = tag_q[victim][idx];
   // controller picks which victim word goes out
   assign victim_word  = data_q[victim][idx][wb_word];

   // valid, dirty and replacement bits
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         valid_q <= '0;
         dirty_q <= '0;
         lru_q   <= '0;
      end
      else if (fill_en) begin
         // fresh block from memory, clean
         valid_q[victim][idx] <= 1'b1;
         dirty_q[victim][idx] <= 1'b0;
         lru_q[idx]           <= victim;
      end
      else if (hit) begin
         lru_q[idx] <= hit_way;
         // store makes the line differ from memory
         if (wr_hit) begin
            dirty_q[hit_way][idx] <= 1'b1;
         end
      end
   end

   // tag and data arrays
   always_ff @(posedge CLK) begin
      if (fill_en) begin
         tag_q[victim][idx]     <= req.f.tag;
         data_q[victim][idx][0] <= fill_data0;
         data_q[victim][idx][1] <= fill_data1;
      end
      else if (wr_hit) begin
         // merge the store word into the block
         data_q[hit_way][idx][blk] <= dmemstore;
      end
   end

endmodule

// File: src/dcache_pkg.sv
/*
 data cache shared definitions
   geometry of the two-way cache (widths of tag, index, block and byte fields)
   set and way counts
   word type
   address union, read as a plain word or as its cache fields
 */

package dcache_pkg;

   // data and address width
   localparam int WORD_W = 32;

   // address field widths, msb to lsb
   localparam int DTAG_W = 26;
   localparam int DIDX_W = 3;
   localparam int DBLK_W = 1;
   localparam int DBYT_W = 2;

   // cache geometry
   localparam int N_SETS = 1 << DIDX_W;
   localparam int N_WAYS = 2;

   // one data word
   typedef logic [WORD_W-1:0] word_t;

   // same 32 bits seen two ways
   // word: raw processor or memory address
   // f: tag / set index / word in block / byte offset
   typedef union packed {
      word_t word;
      struct packed {
         logic [DTAG_W-1:0] tag;
         logic [DIDX_W-1:0] idx;
         logic [DBLK_W-1:0] blk;
         logic [DBYT_W-1:0] byt;
      } f;
   } dcache_addr_u;

endpackage
